// File: source/decodePkg.sv
/*
 * Decode stage shared definitions: widths, opcode and function codes,
 * ALU operation codes, the instruction word views and the issue bundle
 */
`default_nettype none

package decodePkg;

	localparam int XLEN     = 32;
	localparam int REG_BITS = 5;
	localparam int NUM_REGS = 32;
	localparam int ALU_BITS = 6;

	localparam logic [REG_BITS-1:0] LINK_REG = 5'd31;

	// ------------------------------------------------------------
	// Opcode and function codes
	// ------------------------------------------------------------
	localparam logic [5:0] OPC_SPECIAL = 6'h00;
	localparam logic [5:0] OPC_J       = 6'h02;
	localparam logic [5:0] OPC_JAL     = 6'h03;
	localparam logic [5:0] OPC_BEQ     = 6'h04;
	localparam logic [5:0] OPC_BNE     = 6'h05;
	localparam logic [5:0] OPC_ADDI    = 6'h08;
	localparam logic [5:0] OPC_ADDIU   = 6'h09;
	localparam logic [5:0] OPC_SLTI    = 6'h0a;
	localparam logic [5:0] OPC_SLTIU   = 6'h0b;
	localparam logic [5:0] OPC_ANDI    = 6'h0c;
	localparam logic [5:0] OPC_ORI     = 6'h0d;
	localparam logic [5:0] OPC_XORI    = 6'h0e;
	localparam logic [5:0] OPC_LUI     = 6'h0f;
	localparam logic [5:0] OPC_LW      = 6'h23;
	localparam logic [5:0] OPC_SW      = 6'h2b;

	localparam logic [5:0] FN_SLL  = 6'h00;
	localparam logic [5:0] FN_SRL  = 6'h02;
	localparam logic [5:0] FN_SRA  = 6'h03;
	localparam logic [5:0] FN_JR   = 6'h08;
	localparam logic [5:0] FN_JALR = 6'h09;
	localparam logic [5:0] FN_ADD  = 6'h20;
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUB  = 6'h22;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND  = 6'h24;
	localparam logic [5:0] FN_OR   = 6'h25;
	localparam logic [5:0] FN_XOR  = 6'h26;
	localparam logic [5:0] FN_NOR  = 6'h27;
	localparam logic [5:0] FN_SLT  = 6'h2a;
	localparam logic [5:0] FN_SLTU = 6'h2b;

	// ALU operations seen by execute, zero is never issued
	localparam logic [ALU_BITS-1:0] ALU_ADD  = 6'h01; // Also link and address calc
	localparam logic [ALU_BITS-1:0] ALU_SUB  = 6'h1d;
	localparam logic [ALU_BITS-1:0] ALU_AND  = 6'h04;
	localparam logic [ALU_BITS-1:0] ALU_OR   = 6'h10;
	localparam logic [ALU_BITS-1:0] ALU_XOR  = 6'h1f;
	localparam logic [ALU_BITS-1:0] ALU_NOR  = 6'h0f;
	localparam logic [ALU_BITS-1:0] ALU_SLT  = 6'h15;
	localparam logic [ALU_BITS-1:0] ALU_SLTU = 6'h3f;
	localparam logic [ALU_BITS-1:0] ALU_SLL  = 6'h03;
	localparam logic [ALU_BITS-1:0] ALU_SRL  = 6'h1b;
	localparam logic [ALU_BITS-1:0] ALU_SRA  = 6'h19;
	localparam logic [ALU_BITS-1:0] ALU_LUI  = 6'h08;

	// ------------------------------------------------------------
	// Instruction word views
	// ------------------------------------------------------------
	typedef struct packed {
		logic [5:0]          opcode;
		logic [REG_BITS-1:0] rs;
		logic [REG_BITS-1:0] rt;
		logic [REG_BITS-1:0] rd;
		logic [REG_BITS-1:0] shamt;
		logic [5:0]          funct;
	} rType_t;

	typedef struct packed {
		logic [5:0]          opcode;
		logic [REG_BITS-1:0] rs;
		logic [REG_BITS-1:0] rt;
		logic [15:0]         imm;
	} iType_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [25:0] index;
	} jType_t;

	typedef union packed {
		rType_t rFields;
		iType_t iFields;
		jType_t jFields;
	} instrWord_t;

	// ------------------------------------------------------------
	// Decoded controls and pipeline bundles
	// ------------------------------------------------------------
	typedef struct packed {
		logic [ALU_BITS-1:0] aluOp;
		logic                aluSrc;      // Operand B from immediate
		logic                memRead;
		logic                memWrite;
		logic                writeEnable;
		logic                isBranch;
		logic                branchNe;
		logic                isJump;
		logic                jumpReg;
		logic                isLink;
		logic                illegal;
	} ctrl_t;

	typedef struct packed {
		logic                writeEnable;
		logic [REG_BITS-1:0] dest;
		logic [XLEN-1:0]     data;
	} fwdPort_t;

	typedef struct packed {
		ctrl_t               ctrl;
		logic [REG_BITS-1:0] dest;
		logic [XLEN-1:0]     operandA;
		logic [XLEN-1:0]     operandB;
		logic [XLEN-1:0]     storeData;
		logic [REG_BITS-1:0] shamt;
		logic                takenBranch;
		logic [XLEN-1:0]     nextPc;
	} issue_t;

endpackage

`default_nettype wire

// File: source/instrDecoder.sv
/*
 * Control decoder: instruction word to control bits, destination
 * register and extended immediate
 */
`timescale 1ns/1ps
`default_nettype none

module instrDecoder import decodePkg::*; (
	input  instrWord_t          instr,
	output ctrl_t               ctrl,
	output logic [REG_BITS-1:0] dest,
	output logic [XLEN-1:0]     imm
);

	ctrl_t decoded;
	logic  useRd;     // R-type destination
	logic  zeroExt;   // Logical immediates
	logic  upperImm;  // lui

	always_comb begin
		decoded  = '0;
		useRd    = 1'b0;
		zeroExt  = 1'b0;
		upperImm = 1'b0;
		case (instr.rFields.opcode)
			OPC_SPECIAL: begin
				useRd               = 1'b1;
				decoded.writeEnable = 1'b1;
				case (instr.rFields.funct)
					FN_ADD, FN_ADDU: decoded.aluOp = ALU_ADD;
					FN_SUB, FN_SUBU: decoded.aluOp = ALU_SUB;
					FN_AND:          decoded.aluOp = ALU_AND;
					FN_OR:           decoded.aluOp = ALU_OR;
					FN_XOR:          decoded.aluOp = ALU_XOR;
					FN_NOR:          decoded.aluOp = ALU_NOR;
					FN_SLT:          decoded.aluOp = ALU_SLT;
					FN_SLTU:         decoded.aluOp = ALU_SLTU;
					FN_SLL:          decoded.aluOp = ALU_SLL;
					FN_SRL:          decoded.aluOp = ALU_SRL;
					FN_SRA:          decoded.aluOp = ALU_SRA;
					FN_JR: begin
						decoded.aluOp       = ALU_ADD;
						decoded.writeEnable = 1'b0;
						decoded.isJump      = 1'b1;
						decoded.jumpReg     = 1'b1;
					end
					FN_JALR: begin
						decoded.aluOp   = ALU_ADD; // pc+4 plus 4 is not used, link adds
						decoded.isJump  = 1'b1;
						decoded.jumpReg = 1'b1;
						decoded.isLink  = 1'b1;
					end
					default: begin
						decoded         = '0;
						decoded.illegal = 1'b1;
						useRd           = 1'b0;
					end
				endcase
			end
			OPC_J: begin
				decoded.aluOp  = ALU_ADD;
				decoded.isJump = 1'b1;
			end
			OPC_JAL: begin
				decoded.aluOp       = ALU_ADD;
				decoded.isJump      = 1'b1;
				decoded.isLink      = 1'b1;
				decoded.writeEnable = 1'b1;
			end
			OPC_BEQ, OPC_BNE: begin
				decoded.aluOp    = ALU_SUB;
				decoded.isBranch = 1'b1;
				decoded.branchNe = (instr.rFields.opcode == OPC_BNE);
			end
			OPC_ADDI, OPC_ADDIU, OPC_SLTI, OPC_SLTIU,
			OPC_ANDI, OPC_ORI, OPC_XORI, OPC_LUI: begin
				decoded.aluSrc      = 1'b1;
				decoded.writeEnable = 1'b1;
				case (instr.rFields.opcode)
					OPC_SLTI:  decoded.aluOp = ALU_SLT;
					OPC_SLTIU: decoded.aluOp = ALU_SLTU;
					OPC_ANDI:  decoded.aluOp = ALU_AND;
					OPC_ORI:   decoded.aluOp = ALU_OR;
					OPC_XORI:  decoded.aluOp = ALU_XOR;
					OPC_LUI:   decoded.aluOp = ALU_LUI;
					default:   decoded.aluOp = ALU_ADD;
				endcase
				zeroExt  = (decoded.aluOp == ALU_AND) || (decoded.aluOp == ALU_OR) ||
				           (decoded.aluOp == ALU_XOR);
				upperImm = (decoded.aluOp == ALU_LUI);
			end
			OPC_LW: begin
				decoded.aluOp       = ALU_ADD; // Address = rs + offset
				decoded.aluSrc      = 1'b1;
				decoded.memRead     = 1'b1;
				decoded.writeEnable = 1'b1;
			end
			OPC_SW: begin
				decoded.aluOp    = ALU_ADD;
				decoded.aluSrc   = 1'b1;
				decoded.memWrite = 1'b1;
			end
			default: decoded.illegal = 1'b1;
		endcase
	end

	// Link always targets r31, jalr included
	assign dest = decoded.isLink ? LINK_REG :
	              (useRd ? instr.rFields.rd : instr.iFields.rt);

	always_comb begin
		ctrl             = decoded;
		ctrl.writeEnable = decoded.writeEnable && (dest != '0); // r0 never written
	end

	always_comb begin
		if (upperImm)
			imm = {instr.iFields.imm, {(XLEN-16){1'b0}}};
		else if (zeroExt)
			imm = {{(XLEN-16){1'b0}}, instr.iFields.imm};
		else
			imm = {{(XLEN-16){instr.iFields.imm[15]}}, instr.iFields.imm};
	end

endmodule

`default_nettype wire

// File: source/operandFetch.sv
/*
 * Operand fetch: register file written from writeback, and source
 * operand forwarding from execute, memory and writeback
 */
`timescale 1ns/1ps
`default_nettype none

module operandFetch import decodePkg::*; (
	input  wire logic       CLK,
	input  wire logic       RESET,
	input  instrWord_t      instr,
	input  fwdPort_t        exFwd,
	input  fwdPort_t        memFwd,
	input  fwdPort_t        wbFwd,
	output logic [XLEN-1:0] rsValue,
	output logic [XLEN-1:0] rtValue
);

	logic [XLEN-1:0]     regFile [NUM_REGS];
	logic [REG_BITS-1:0] rsIdx;
	logic [REG_BITS-1:0] rtIdx;

	// Newest producer wins, r0 is hardwired
	function automatic logic [XLEN-1:0] pickOperand(
		input logic [REG_BITS-1:0] idx,
		input logic [XLEN-1:0]     fileValue,
		input fwdPort_t            ex,
		input fwdPort_t            mem,
		input fwdPort_t            wb
	);
		if (idx == '0)
			return '0;
		else if (ex.writeEnable && (ex.dest == idx))
			return ex.data;
		else if (mem.writeEnable && (mem.dest == idx))
			return mem.data;
		else if (wb.writeEnable && (wb.dest == idx))
			return wb.data;
		else
			return fileValue;
	endfunction

	// ------------------------------------------------------------
	// Register file
	// ------------------------------------------------------------
	always_ff @(posedge CLK or negedge RESET) begin
		if (!RESET) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regFile[i] <= '0;
			end
		end else if (wbFwd.writeEnable && (wbFwd.dest != '0)) begin
			regFile[wbFwd.dest] <= wbFwd.data;
		end
	end

	// ------------------------------------------------------------
	// Source operands
	// ------------------------------------------------------------
	assign rsIdx = instr.rFields.rs;
	assign rtIdx = instr.rFields.rt;

	assign rsValue = pickOperand(rsIdx, regFile[rsIdx], exFwd, memFwd, wbFwd);
	assign rtValue = pickOperand(rtIdx, regFile[rtIdx], exFwd, memFwd, wbFwd);

endmodule

`default_nettype wire

// File: source/issueLatch.sv
/*
 * Issue latch: branch resolution, next address, operand selection
 * and the valid/ready output register toward execute
 */
`timescale 1ns/1ps
`default_nettype none

module issueLatch import decodePkg::*; (
	input  wire logic           CLK,
	input  wire logic           RESET,
	input  wire logic           inValid,
	output logic                inReady,
	input  instrWord_t          instr,
	input  wire [XLEN-1:0]      pc,
	input  ctrl_t               ctrl,
	input  wire [REG_BITS-1:0]  dest,
	input  wire [XLEN-1:0]      imm,
	input  wire [XLEN-1:0]      rsValue,
	input  wire [XLEN-1:0]      rtValue,
	input  wire [XLEN-1:0]      exResult,
	output logic                outValid,
	input  wire logic           outReady,
	output issue_t              issue,
	output fwdPort_t            exFwd
);

	logic [XLEN-1:0] pcPlus4;
	logic [XLEN-1:0] branchTarget;
	logic [XLEN-1:0] jumpTarget;
	logic            taken;
	logic            load;
	issue_t          nextIssue;

	// ------------------------------------------------------------
	// Control flow
	// ------------------------------------------------------------
	assign pcPlus4      = pc + XLEN'(4);
	assign branchTarget = pcPlus4 + (imm << 2);
	assign jumpTarget   = {pcPlus4[XLEN-1 -: 4], instr.jFields.index, 2'b00};

	// beq takes on equal, bne on not equal
	assign taken = ctrl.isBranch && ((rsValue == rtValue) != ctrl.branchNe);

	always_comb begin
		nextIssue             = '0;
		nextIssue.ctrl        = ctrl;
		nextIssue.dest        = dest;
		nextIssue.storeData   = rtValue;
		nextIssue.shamt       = instr.rFields.shamt;
		nextIssue.takenBranch = taken;

		if (ctrl.jumpReg)
			nextIssue.nextPc = rsValue;     // jr, jalr
		else if (ctrl.isJump)
			nextIssue.nextPc = jumpTarget;
		else if (taken)
			nextIssue.nextPc = branchTarget;
		else
			nextIssue.nextPc = pcPlus4;

		// Link computes pc+4 + 4 in execute
		if (ctrl.isLink) begin
			nextIssue.operandA = pcPlus4;
			nextIssue.operandB = XLEN'(4);
		end else begin
			nextIssue.operandA = rsValue;
			nextIssue.operandB = ctrl.aluSrc ? imm : rtValue;
		end
	end

	// ------------------------------------------------------------
	// Output register
	// ------------------------------------------------------------
	assign inReady = !outValid || outReady;  // Slot empty or draining
	assign load    = inValid && inReady;

	always_ff @(posedge CLK or negedge RESET) begin
		if (!RESET) begin
			outValid <= 1'b0;
			issue    <= '0;
		end else begin
			if (inReady)
				outValid <= inValid;
			if (load)
				issue <= nextIssue;
		end
	end

	// Held instruction feeds back its ALU result, loads are not ready yet
	assign exFwd.writeEnable = outValid && issue.ctrl.writeEnable && !issue.ctrl.memRead;
	assign exFwd.dest        = issue.dest;
	assign exFwd.data        = exResult;

endmodule

`default_nettype wire

// File: source/decodeStage.sv
/*
 * Decode stage top: control decoder and operand fetch side by side,
 * joined in the issue latch
 */
`timescale 1ns/1ps
`default_nettype none

module decodeStage import decodePkg::*; (
	input  wire logic      CLK,
	input  wire logic      RESET,
	// Fetch side
	input  wire logic      inValid,
	output logic           inReady,
	input  instrWord_t     instr,
	input  wire [XLEN-1:0] pc,
	// Execute side
	output logic           outValid,
	input  wire logic      outReady,
	output issue_t         issue,
	input  wire [XLEN-1:0] exResult,
	// Later stages
	input  fwdPort_t       memFwd,
	input  fwdPort_t       wbFwd
);

	ctrl_t               ctrl;
	logic [REG_BITS-1:0] dest;
	logic [XLEN-1:0]     imm;
	logic [XLEN-1:0]     rsValue;
	logic [XLEN-1:0]     rtValue;
	fwdPort_t            exFwd;

	instrDecoder u_decoder (
		.instr (instr),
		.ctrl  (ctrl),
		.dest  (dest),
		.imm   (imm)
	);

	operandFetch u_operands (
		.CLK     (CLK),
		.RESET   (RESET),
		.instr   (instr),
		.exFwd   (exFwd),
		.memFwd  (memFwd),
		.wbFwd   (wbFwd),
		.rsValue (rsValue),
		.rtValue (rtValue)
	);

	issueLatch u_issue (
		.CLK      (CLK),
		.RESET    (RESET),
		.inValid  (inValid),
		.inReady  (inReady),
		.instr    (instr),
		.pc       (pc),
		.ctrl     (ctrl),
		.dest     (dest),
		.imm      (imm),
		.rsValue  (rsValue),
		.rtValue  (rtValue),
		.exResult (exResult),
		.outValid (outValid),
		.outReady (outReady),
		.issue    (issue),
		.exFwd    (exFwd)
	);

endmodule

`default_nettype wire

// File: verif/tbVectors.svh
/*
 * Decode stage test table: one instruction per row with its
 * forwarding inputs, back-pressure and expected issue fields
 */
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

localparam int NUM_ROWS = 23;

vector_t vectors [NUM_ROWS];

// Columns: instr, pc, memFwd, wbFwd, exResult, hold
//          aluOp, dest, shamt, flags, operandA, operandB, storeData, nextPc
task automatic loadVectors();
	// Register writes, r0 destination
	vectors[0]  = '{rWord(FN_ADD, 5'd1, 5'd2, 5'd3), 32'h100, '0, '0, 32'h0, 0,
	                ALU_ADD, 5'd3, 5'd0, 11'b00010000000, 32'h0, 32'h0, 32'h0, 32'h104};
	vectors[1]  = '{rWord(FN_AND, 5'd1, 5'd0, 5'd5), 32'h104, '0, portWrite(5'd1, 32'h1111),
	                32'h0, 0, ALU_AND, 5'd5, 5'd0, 11'b00010000000,
	                32'h1111, 32'h0, 32'h0, 32'h108};
	vectors[2]  = '{rWord(FN_SUB, 5'd1, 5'd2, 5'd6), 32'h108, '0, portWrite(5'd2, 32'h2222),
	                32'h0, 0, ALU_SUB, 5'd6, 5'd0, 11'b00010000000,
	                32'h1111, 32'h2222, 32'h2222, 32'h10c};
	vectors[3]  = '{rWord(FN_SLT, 5'd1, 5'd2, 5'd0), 32'h10c, '0,
	                portWrite(5'd7, 32'h8000_0000), 32'h0, 0,
	                ALU_SLT, 5'd0, 5'd0, 11'b00000000000, 32'h1111, 32'h2222, 32'h2222, 32'h110};
	// Immediates and memory
	vectors[4]  = '{iWord(OPC_ADDI, 5'd1, 5'd8, 16'hfffc), 32'h110, '0, '0, 32'h0, 0,
	                ALU_ADD, 5'd8, 5'd31, 11'b10010000000,
	                32'h1111, 32'hffff_fffc, 32'h0, 32'h114};
	vectors[5]  = '{iWord(OPC_ORI, 5'd7, 5'd9, 16'h8001), 32'h114, '0, '0, 32'h0, 0,
	                ALU_OR, 5'd9, 5'd0, 11'b10010000000, 32'h8000_0000, 32'h8001, 32'h0, 32'h118};
	vectors[6]  = '{iWord(OPC_LUI, 5'd0, 5'd10, 16'h1234), 32'h118, '0, '0, 32'h0, 0,
	                ALU_LUI, 5'd10, 5'd8, 11'b10010000000, 32'h0, 32'h1234_0000, 32'h0, 32'h11c};
	vectors[7]  = '{iWord(OPC_LW, 5'd1, 5'd11, 16'h0008), 32'h11c, '0, '0, 32'h0, 3,
	                ALU_ADD, 5'd11, 5'd0, 11'b11010000000, 32'h1111, 32'h8, 32'h0, 32'h120};
	vectors[8]  = '{iWord(OPC_SW, 5'd11, 5'd2, 16'h000c), 32'h120, '0, '0, 32'hdead_0000, 0,
	                ALU_ADD, 5'd2, 5'd0, 11'b10100000000, 32'h0, 32'hc, 32'h2222, 32'h124};
	// Forwarding priority on r12
	vectors[9]  = '{rWord(FN_ADD, 5'd1, 5'd2, 5'd12), 32'h124, '0, '0, 32'h0, 0,
	                ALU_ADD, 5'd12, 5'd0, 11'b00010000000,
	                32'h1111, 32'h2222, 32'h2222, 32'h128};
	vectors[10] = '{rWord(FN_OR, 5'd12, 5'd12, 5'd13), 32'h128, portWrite(5'd12, 32'haaaa_0002),
	                portWrite(5'd12, 32'hbbbb_0003), 32'heeee_0001, 0,
	                ALU_OR, 5'd13, 5'd0, 11'b00010000000,
	                32'heeee_0001, 32'heeee_0001, 32'heeee_0001, 32'h12c};
	vectors[11] = '{rWord(FN_XOR, 5'd12, 5'd13, 5'd14), 32'h12c, portWrite(5'd12, 32'haaaa_0004),
	                portWrite(5'd12, 32'hbbbb_0005), 32'h1313_1313, 0,
	                ALU_XOR, 5'd14, 5'd0, 11'b00010000000,
	                32'haaaa_0004, 32'h1313_1313, 32'h1313_1313, 32'h130};
	vectors[12] = '{rWord(FN_NOR, 5'd12, 5'd0, 5'd15), 32'h130, '0,
	                portWrite(5'd12, 32'hbbbb_0006), 32'h0, 0,
	                ALU_NOR, 5'd15, 5'd0, 11'b00010000000, 32'hbbbb_0006, 32'h0, 32'h0, 32'h134};
	vectors[13] = '{32'hfc22_0000, 32'h134, '0, '0, 32'h0, 2,
	                6'h00, 5'd2, 5'd0, 11'b00000000001, 32'h1111, 32'h2222, 32'h2222, 32'h138};
	// Branches and jumps
	vectors[14] = '{iWord(OPC_BEQ, 5'd1, 5'd1, 16'h0004), 32'h200, '0, '0, 32'h0, 0,
	                ALU_SUB, 5'd1, 5'd0, 11'b00001000010,
	                32'h1111, 32'h1111, 32'h1111, 32'h214};
	vectors[15] = '{iWord(OPC_BEQ, 5'd1, 5'd2, 16'hfffe), 32'h300, '0, '0, 32'h0, 0,
	                ALU_SUB, 5'd2, 5'd31, 11'b00001000000,
	                32'h1111, 32'h2222, 32'h2222, 32'h304};
	vectors[16] = '{iWord(OPC_BNE, 5'd1, 5'd2, 16'hfffe), 32'h300, '0, '0, 32'h0, 0,
	                ALU_SUB, 5'd2, 5'd31, 11'b00001100010,
	                32'h1111, 32'h2222, 32'h2222, 32'h2fc};
	vectors[17] = '{iWord(OPC_BNE, 5'd2, 5'd2, 16'h0010), 32'h400, '0, '0, 32'h0, 0,
	                ALU_SUB, 5'd2, 5'd0, 11'b00001100000,
	                32'h2222, 32'h2222, 32'h2222, 32'h404};
	vectors[18] = '{jWord(OPC_J, 26'h004_0000), 32'h1000_0040, '0, '0, 32'h0, 0,
	                ALU_ADD, 5'd4, 5'd0, 11'b00000010000, 32'h0, 32'h0, 32'h0, 32'h1010_0000};
	vectors[19] = '{jWord(OPC_JAL, 26'h000_0100), 32'h2000_0000, '0, '0, 32'h0, 0,
	                ALU_ADD, 5'd31, 5'd4, 11'b00010010100,
	                32'h2000_0004, 32'h4, 32'h0, 32'h2000_0400};
	vectors[20] = '{rWord(FN_JR, 5'd12, 5'd0, 5'd0), 32'h500, '0, '0, 32'h0, 0,
	                ALU_ADD, 5'd0, 5'd0, 11'b00000011000,
	                32'hbbbb_0006, 32'h0, 32'h0, 32'hbbbb_0006};
	vectors[21] = '{rWord(FN_JALR, 5'd1, 5'd0, 5'd31), 32'h600, '0, '0, 32'h0, 0,
	                ALU_ADD, 5'd31, 5'd0, 11'b00010011100, 32'h604, 32'h4, 32'h0, 32'h1111};
	vectors[22] = '{rWord(FN_ADDU, 5'd31, 5'd0, 5'd16), 32'h700, '0, '0, 32'h608, 0,
	                ALU_ADD, 5'd16, 5'd0, 11'b00010000000, 32'h608, 32'h0, 32'h0, 32'h704};
endtask

`endif

// File: verif/tbDecodeStage.sv
/*
 * Decode stage testbench: walks the instruction table through the DUT
 * and checks each issued bundle, including output back-pressure
 */
`timescale 1ns/1ps
`default_nettype none

module tbDecodeStage import decodePkg::*; ();

	localparam int WAIT_LIMIT = 20; // Cycles allowed per wait

	// Flags from the top bit down: aluSrc memRead memWrite writeEnable isBranch
	// branchNe isJump jumpReg isLink takenBranch illegal
	typedef struct {
		logic [31:0] instr;
		logic [31:0] pc;
		fwdPort_t    memFwd;
		fwdPort_t    wbFwd;
		logic [31:0] exResult;  // Result of the instruction held at issue
		int          hold;      // outReady low cycles after this row issues
		logic [5:0]  aluOp;
		logic [4:0]  dest;
		logic [4:0]  shamt;
		logic [10:0] flags;
		logic [31:0] operandA;
		logic [31:0] operandB;
		logic [31:0] storeData;
		logic [31:0] nextPc;
	} vector_t;

	logic        CLK;
	logic        RESET;
	logic        inValid;
	logic        inReady;
	instrWord_t  instr;
	logic [31:0] pc;
	logic        outValid;
	logic        outReady;
	issue_t      issue;
	logic [31:0] exResult;
	fwdPort_t    memFwd;
	fwdPort_t    wbFwd;

	issue_t      heldIssue;
	int          pendingHold;

	// ------------------------------------------------------------
	// Instruction and forwarding encoders
	// ------------------------------------------------------------
	function automatic logic [31:0] rWord(input logic [5:0] funct, input logic [4:0] rs,
			input logic [4:0] rt, input logic [4:0] rd);
		return {OPC_SPECIAL, rs, rt, rd, 5'd0, funct};
	endfunction

	function automatic logic [31:0] iWord(input logic [5:0] opcode, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] imm);
		return {opcode, rs, rt, imm};
	endfunction

	function automatic logic [31:0] jWord(input logic [5:0] opcode, input logic [25:0] index);
		return {opcode, index};
	endfunction

	function automatic fwdPort_t portWrite(input logic [4:0] dest, input logic [31:0] data);
		fwdPort_t port;
		port.writeEnable = 1'b1;
		port.dest        = dest;
		port.data        = data;
		return port;
	endfunction

	`include "tbVectors.svh"

	decodeStage u_dut (
		.CLK      (CLK),
		.RESET    (RESET),
		.inValid  (inValid),
		.inReady  (inReady),
		.instr    (instr),
		.pc       (pc),
		.outValid (outValid),
		.outReady (outReady),
		.issue    (issue),
		.exResult (exResult),
		.memFwd   (memFwd),
		.wbFwd    (wbFwd)
	);

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	// ------------------------------------------------------------
	// Checks and handshake helpers
	// ------------------------------------------------------------
	task automatic checkValue(input string name, input logic [159:0] expected,
			input logic [159:0] actual);
		if (expected !== actual) begin
			$display("mismatch at %0t: %s expected %0h actual %0h", $time, name, expected,
			         actual);
			$display("FAIL: see errors above");
			$fatal(1, "value check failed");
		end
	endtask

	task automatic applyRow(input int row);
		inValid  = 1'b1;
		instr    = vectors[row].instr;
		pc       = vectors[row].pc;
		memFwd   = vectors[row].memFwd;
		wbFwd    = vectors[row].wbFwd;
		exResult = vectors[row].exResult;
	endtask

	// Stalls execute and watches the held bundle
	task automatic holdOutput(input int cycles);
		outReady = 1'b0;
		repeat (cycles) begin
			@(posedge CLK);
			#1;
			checkValue("outValid during hold", 160'(1'b1), 160'(outValid));
			checkValue("inReady during hold", 160'(1'b0), 160'(inReady));
			checkValue("issue during hold", 160'(heldIssue), 160'(issue));
		end
		outReady = 1'b1;
		#1; // Let inReady settle
	endtask

	task automatic acceptRow(input int row);
		int count;
		count = 0;
		while (!inReady) begin
			if (count == WAIT_LIMIT) begin
				$display("timeout: inReady stayed low while sending row %0d", row);
				$display("FAIL: see errors above");
				$fatal(1, "inReady timeout");
			end else begin
				@(posedge CLK);
				#1;
				count++;
			end
		end
		@(posedge CLK); // Transfer edge
		#1;
	endtask

	task automatic collectIssue(input int row);
		int    count;
		string tag;
		count = 0;
		tag   = $sformatf("row %0d ", row);
		while (!outValid) begin
			if (count == WAIT_LIMIT) begin
				$display("timeout: no issued bundle appeared for row %0d", row);
				$display("FAIL: see errors above");
				$fatal(1, "outValid timeout");
			end else begin
				@(posedge CLK);
				#1;
				count++;
			end
		end
		checkValue({tag, "aluOp"}, 160'(vectors[row].aluOp), 160'(issue.ctrl.aluOp));
		checkValue({tag, "dest"}, 160'(vectors[row].dest), 160'(issue.dest));
		checkValue({tag, "shamt"}, 160'(vectors[row].shamt), 160'(issue.shamt));
		checkValue({tag, "flags"}, 160'(vectors[row].flags),
		           160'({issue.ctrl.aluSrc, issue.ctrl.memRead, issue.ctrl.memWrite,
		                 issue.ctrl.writeEnable, issue.ctrl.isBranch, issue.ctrl.branchNe,
		                 issue.ctrl.isJump, issue.ctrl.jumpReg, issue.ctrl.isLink,
		                 issue.takenBranch, issue.ctrl.illegal}));
		checkValue({tag, "operandA"}, 160'(vectors[row].operandA), 160'(issue.operandA));
		checkValue({tag, "operandB"}, 160'(vectors[row].operandB), 160'(issue.operandB));
		checkValue({tag, "storeData"}, 160'(vectors[row].storeData), 160'(issue.storeData));
		checkValue({tag, "nextPc"}, 160'(vectors[row].nextPc), 160'(issue.nextPc));
	endtask

	// ------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------
	initial begin
		RESET       = 1'b0;
		inValid     = 1'b0;
		instr       = '0;
		pc          = '0;
		outReady    = 1'b1;
		exResult    = '0;
		memFwd      = '0;
		wbFwd       = '0;
		heldIssue   = '0;
		pendingHold = 0;
		loadVectors();

		repeat (8) @(posedge CLK);
		#1;
		RESET = 1'b1;
		checkValue("outValid after reset", 160'(1'b0), 160'(outValid));
		checkValue("inReady after reset", 160'(1'b1), 160'(inReady));

		for (int row = 0; row < NUM_ROWS; row++) begin
			applyRow(row);
			if (pendingHold > 0)
				holdOutput(pendingHold);
			acceptRow(row);
			collectIssue(row);
			heldIssue   = issue;
			pendingHold = vectors[row].hold;
		end

		inValid = 1'b0;
		memFwd  = '0;
		wbFwd   = '0;
		@(posedge CLK);
		#1;
		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+verif
source/decodePkg.sv
source/instrDecoder.sv
source/operandFetch.sv
source/issueLatch.sv
source/decodeStage.sv
verif/tbDecodeStage.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tbDecodeStage
FILELIST  ?= verilog.f
OBJDIR    ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
